/* include/dot11_tx_defs.svh */
/* Widths and constants of the legacy OFDM transmit bit front end.
   Rate codes are the 4-bit RATE values of the legacy SIGNAL field. */
`ifndef DOT11_TX_DEFS_SVH
`define DOT11_TX_DEFS_SVH

// Block RAM interface
`define DOT11_BRAM_W        64
`define DOT11_BRAM_AW       10

// Counter and register widths
`define DOT11_SCRAM_W       7
`define DOT11_PSDU_BITS_W   19
`define DOT11_DBPS_W        9

// Field lengths in bits
`define DOT11_SIG_BITS      24
`define DOT11_SERVICE_BITS  16
`define DOT11_FCS_BITS      32
`define DOT11_TAIL_BITS     6

// Convolutional encoder generators, MSB is the current input
`define DOT11_GEN0          7'o133
`define DOT11_GEN1          7'o171

// Reflected IEEE 802.3 polynomial
`define DOT11_CRC_POLY      32'hEDB88320

// Legacy rate codes
`define DOT11_RATE_6M       4'b1011
`define DOT11_RATE_9M       4'b1111
`define DOT11_RATE_12M      4'b1010
`define DOT11_RATE_18M      4'b1110
`define DOT11_RATE_24M      4'b1001
`define DOT11_RATE_36M      4'b1101
`define DOT11_RATE_48M      4'b1000
`define DOT11_RATE_54M      4'b1100

`endif

/* hw/dot11_tx_pkg.sv */
/* Types shared by the transmit bit front end.
   Encoded pair bit 0 comes from generator 133, bit 1 from generator 171. */
`include "dot11_tx_defs.svh"

package dot11_tx_pkg;

    // Vector types
    typedef logic [`DOT11_BRAM_W-1:0]      bram_word_t;
    typedef logic [`DOT11_BRAM_AW-1:0]     bram_addr_t;
    typedef logic [`DOT11_SCRAM_W-1:0]     scram_state_t;
    typedef logic [`DOT11_PSDU_BITS_W-1:0] psdu_bits_t;
    typedef logic [`DOT11_DBPS_W-1:0]      dbps_t;
    typedef logic [3:0]                    rate_code_t;
    typedef logic [1:0]                    enc_pair_t;
    typedef logic [`DOT11_FCS_BITS-1:0]    crc_t;

    // Packet field sequencer
    typedef enum logic [2:0] {IDLE, SIGNAL, SERVICE, PSDU, FCS, TAIL, PAD} tx_state_t;

    // Per-packet rate, latched from the SIGNAL word
    typedef struct packed {
        rate_code_t rate;
        dbps_t      n_dbps;
    } rate_params_t;

    typedef struct packed {
        logic bit_in;
        logic advance;
        logic clear;
    } enc_ctrl_t;

    typedef struct packed {
        logic [3:0] nibble;
        logic       strobe;
        logic       clear;
    } crc_ctrl_t;

endpackage

/* hw/dot11_crc32.sv */
/* CRC-32 over the PSDU payload, four bits per strobe, LSB first.
   Clear and strobe are not expected in the same cycle; clear wins. */
`timescale 1ns/1ps
`include "dot11_tx_defs.svh"

module dot11_crc32
    import dot11_tx_pkg::*;
(
    input  logic      clk,
    input  logic      reset_int,
    input  crc_ctrl_t i_crc_ctrl,
    output crc_t      o_fcs
);

    crc_t crc_q;

    // One nibble through the reflected shift register
    function automatic crc_t crc_nibble(crc_t c, logic [3:0] d);
        crc_t r;
        r = c;
        for (int i = 0; i < 4; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ `DOT11_CRC_POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_int) begin
            crc_q <= '1;
        end else if (i_crc_ctrl.clear) begin
            crc_q <= '1;
        end else if (i_crc_ctrl.strobe) begin
            crc_q <= crc_nibble(crc_q, i_crc_ctrl.nibble);
        end
    end

    // FCS is the complemented register
    assign o_fcs = ~crc_q;

endmodule

/* hw/dot11_conv_encoder.sv */
/* Rate-1/2, K=7 convolutional encoder, generators 133 and 171 octal.
   Output pair is combinational; clear encodes the current bit against zero history. */
`timescale 1ns/1ps
`include "dot11_tx_defs.svh"

module dot11_conv_encoder
    import dot11_tx_pkg::*;
(
    input  logic      clk,
    input  logic      reset_int,
    input  enc_ctrl_t i_enc_ctrl,
    output enc_pair_t o_bits
);

    // hist[5] is the previous bit, hist[0] the oldest
    logic [5:0] hist;
    logic [5:0] hist_eff;
    logic [6:0] window;

    assign hist_eff = i_enc_ctrl.clear ? 6'd0 : hist;
    assign window   = {i_enc_ctrl.bit_in, hist_eff};

    // Generator parities
    assign o_bits[0] = ^(window & `DOT11_GEN0);
    assign o_bits[1] = ^(window & `DOT11_GEN1);

    always_ff @(posedge clk) begin
        if (reset_int) begin
            hist <= '0;
        end else if (i_enc_ctrl.advance) begin
            hist <= window[6:1];
        end
    end

    // Clear covers only the first bit of a field
    assert property (@(posedge clk) disable iff (reset_int)
        i_enc_ctrl.clear && i_enc_ctrl.advance |=> !i_enc_ctrl.clear);

endmodule

/* hw/dot11_bit_source.sv */
/* Packet sequencer of the legacy transmit bit stream.
   RAM read latency is one cycle; length in word 0 counts the FCS and must be 4 or more.
   Unknown rate codes are sent as 6 Mbps. */
`timescale 1ns/1ps
`include "dot11_tx_defs.svh"

module dot11_bit_source
    import dot11_tx_pkg::*;
(
    input  logic         clk,
    input  logic         reset_int,
    input  logic         i_tx_start,
    input  scram_state_t i_init_scram_state,
    input  bram_word_t   i_bram_din,
    input  crc_t         i_fcs,
    input  logic         i_enc_ready,
    output bram_addr_t   o_bram_addr,
    output enc_ctrl_t    o_enc_ctrl,
    output crc_ctrl_t    o_crc_ctrl,
    output logic         o_enc_valid,
    output logic         o_tx_started,
    output logic         o_tx_done
);

    tx_state_t    state;
    logic [4:0]   fld_cnt;
    psdu_bits_t   psdu_cnt;
    psdu_bits_t   psdu_len;
    dbps_t        dbps_cnt;
    rate_params_t rate_q;
    scram_state_t scram;
    logic [3:0]   nib_q;
    logic         sig_tail_q;
    logic         accept;
    logic         sym_end;
    logic         scram_bit;
    logic         psdu_bit;
    logic         tx_bit;
    logic [3:0]   crc_nib;

    function automatic rate_params_t decode_rate(rate_code_t code);
        rate_params_t p;
        p.rate = code;
        case (code)
            `DOT11_RATE_6M:  p.n_dbps = dbps_t'(24);
            `DOT11_RATE_9M:  p.n_dbps = dbps_t'(36);
            `DOT11_RATE_12M: p.n_dbps = dbps_t'(48);
            `DOT11_RATE_18M: p.n_dbps = dbps_t'(72);
            `DOT11_RATE_24M: p.n_dbps = dbps_t'(96);
            `DOT11_RATE_36M: p.n_dbps = dbps_t'(144);
            `DOT11_RATE_48M: p.n_dbps = dbps_t'(192);
            `DOT11_RATE_54M: p.n_dbps = dbps_t'(216);
            default: begin
                p.rate   = `DOT11_RATE_6M;
                p.n_dbps = dbps_t'(24);
            end
        endcase
        return p;
    endfunction

    assign o_enc_valid  = (state != IDLE);
    assign accept       = o_enc_valid && i_enc_ready;
    assign sym_end      = (dbps_cnt == rate_q.n_dbps - 1'b1);
    assign o_tx_started = accept && (state == SIGNAL) && (fld_cnt == '0);

    ////////////////////////////////////////////////
    // Bit selection and scrambling
    ////////////////////////////////////////////////
    always_comb begin
        scram_bit = scram[6] ^ scram[3];
        // Bit 63 comes from the held nibble, the address has already moved
        if (psdu_cnt[5:0] == 6'd63) begin
            psdu_bit = nib_q[3];
        end else begin
            psdu_bit = i_bram_din[psdu_cnt[5:0]];
        end
        case (state)
            SIGNAL:  tx_bit = (fld_cnt == 5'(`DOT11_SIG_BITS - 1)) ? sig_tail_q
                                                                 : i_bram_din[fld_cnt];
            SERVICE: tx_bit = scram_bit;
            PSDU:    tx_bit = scram_bit ^ psdu_bit;
            FCS:     tx_bit = scram_bit ^ i_fcs[fld_cnt];
            PAD:     tx_bit = scram_bit;
            default: tx_bit = 1'b0;
        endcase
    end

    assign crc_nib = (psdu_cnt[5:2] == 4'hF) ? nib_q : i_bram_din[{psdu_cnt[5:2], 2'b00} +: 4];

    assign o_enc_ctrl = '{
        bit_in:  tx_bit,
        advance: accept,
        clear:   (state == SIGNAL || state == SERVICE) && (fld_cnt == '0)
    };

    assign o_crc_ctrl = '{
        nibble: crc_nib,
        strobe: accept && (state == PSDU) && (psdu_cnt[1:0] == 2'b11),
        clear:  (state == IDLE) && i_tx_start
    };

    ////////////////////////////////////////////////
    // Packet state machine
    ////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            state       <= IDLE;
            fld_cnt     <= '0;
            psdu_cnt    <= '0;
            dbps_cnt    <= '0;
            o_bram_addr <= '0;
            o_tx_done   <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (state == IDLE) begin
                if (i_tx_start) begin
                    state   <= SIGNAL;
                    fld_cnt <= '0;
                end
            end else if (i_enc_ready) begin
                fld_cnt <= fld_cnt + 1'b1;
                // Symbol position counts DATA bits only
                if (state == SIGNAL) begin
                    dbps_cnt <= '0;
                end else begin
                    dbps_cnt <= sym_end ? dbps_t'(0) : dbps_cnt + 1'b1;
                end
                case (state)
                    SIGNAL: begin
                        if (fld_cnt == 5'(`DOT11_SIG_BITS - 2)) begin
                            o_bram_addr <= bram_addr_t'(1);
                        end
                        if (fld_cnt == 5'(`DOT11_SIG_BITS - 1)) begin
                            fld_cnt <= '0;
                            state   <= SERVICE;
                        end
                    end
                    SERVICE: begin
                        if (fld_cnt == 5'(`DOT11_SERVICE_BITS - 2)) begin
                            o_bram_addr <= bram_addr_t'(2);
                        end
                        if (fld_cnt == 5'(`DOT11_SERVICE_BITS - 1)) begin
                            fld_cnt  <= '0;
                            psdu_cnt <= '0;
                            state    <= (psdu_len == '0) ? FCS : PSDU;
                        end
                    end
                    PSDU: begin
                        psdu_cnt <= psdu_cnt + 1'b1;
                        if (psdu_cnt[5:0] == 6'd62) begin
                            o_bram_addr <= o_bram_addr + 1'b1;
                        end
                        if (psdu_cnt == psdu_len - 1'b1) begin
                            fld_cnt <= '0;
                            state   <= FCS;
                        end
                    end
                    FCS: begin
                        if (fld_cnt == 5'(`DOT11_FCS_BITS - 1)) begin
                            fld_cnt <= '0;
                            state   <= TAIL;
                        end
                    end
                    TAIL: begin
                        if (fld_cnt == 5'(`DOT11_TAIL_BITS - 1)) begin
                            state <= PAD;
                            if (sym_end) begin
                                state       <= IDLE;
                                o_bram_addr <= '0;
                                o_tx_done   <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        if (sym_end) begin
                            state       <= IDLE;
                            o_bram_addr <= '0;
                            o_tx_done   <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Word 0 fields, held RAM bits and the data scrambler
    always_ff @(posedge clk) begin
        if (accept) begin
            nib_q <= i_bram_din[`DOT11_BRAM_W-1 -: 4];
            if (state == SIGNAL && fld_cnt == '0) begin
                rate_q   <= decode_rate(i_bram_din[3:0]);
                psdu_len <= {4'd0, i_bram_din[16:5], 3'd0} - psdu_bits_t'(`DOT11_FCS_BITS);
            end
            if (state == SIGNAL && fld_cnt == 5'(`DOT11_SIG_BITS - 2)) begin
                sig_tail_q <= i_bram_din[`DOT11_SIG_BITS-1];
            end
            if (state == SIGNAL) begin
                if (fld_cnt == 5'(`DOT11_SIG_BITS - 1)) begin
                    scram <= i_init_scram_state;
                end
            end else if (state != TAIL) begin
                scram <= {scram[5:0], scram_bit};
            end
        end
    end

    // RAM read holds under back-pressure and otherwise steps one word or returns to 0
    assert property (@(posedge clk) disable iff (reset_int)
        !$stable(o_bram_addr) |-> $past(i_enc_ready) &&
            (o_bram_addr == $past(o_bram_addr) + 1'b1 || o_bram_addr == '0));

    // Last payload bit closes a nibble, so the FCS is complete before its field
    assert property (@(posedge clk) disable iff (reset_int)
        accept && (state == PSDU) && (psdu_cnt == psdu_len - 1'b1) |-> o_crc_ctrl.strobe);

endmodule

/* hw/dot11_tx_bits.sv */
/* Bit front end of the legacy OFDM transmitter.
   Streams encoded SIGNAL and DATA pairs for one packet per start pulse. */
`timescale 1ns/1ps

module dot11_tx_bits
    import dot11_tx_pkg::*;
(
    input  logic         clk,
    input  logic         reset_int,
    input  logic         i_tx_start,
    input  scram_state_t i_init_scram_state,
    input  bram_word_t   i_bram_din,
    output bram_addr_t   o_bram_addr,
    input  logic         i_enc_ready,
    output logic         o_enc_valid,
    output enc_pair_t    o_enc_bits,
    output logic         o_tx_started,
    output logic         o_tx_done
);

    enc_ctrl_t enc_ctrl;
    crc_ctrl_t crc_ctrl;
    crc_t      fcs;

    dot11_bit_source u_bit_source (
        .clk                (clk),
        .reset_int          (reset_int),
        .i_tx_start         (i_tx_start),
        .i_init_scram_state (i_init_scram_state),
        .i_bram_din         (i_bram_din),
        .i_fcs              (fcs),
        .i_enc_ready        (i_enc_ready),
        .o_bram_addr        (o_bram_addr),
        .o_enc_ctrl         (enc_ctrl),
        .o_crc_ctrl         (crc_ctrl),
        .o_enc_valid        (o_enc_valid),
        .o_tx_started       (o_tx_started),
        .o_tx_done          (o_tx_done)
    );

    dot11_crc32 u_crc32 (
        .clk        (clk),
        .reset_int  (reset_int),
        .i_crc_ctrl (crc_ctrl),
        .o_fcs      (fcs)
    );

    dot11_conv_encoder u_conv_encoder (
        .clk        (clk),
        .reset_int  (reset_int),
        .i_enc_ctrl (enc_ctrl),
        .o_bits     (o_enc_bits)
    );

endmodule

/* verif/dot11_tx_checker.sv */
/* Reference model and scoreboard of the transmit bit front end.
   Expected pairs are built when a start pulse reaches an idle DUT.
   RAM words come from ram_word, which the testbench also uses to fill its RAM model. */
`timescale 1ns/1ps

module dot11_tx_checker
    import dot11_tx_pkg::*;
(
    input  logic         clk,
    input  logic         reset_int,
    input  logic         i_tx_start,
    input  logic         i_enc_ready,
    input  logic         i_enc_valid,
    input  enc_pair_t    i_enc_bits,
    input  logic         i_tx_started,
    input  logic         i_tx_done,
    input  bram_addr_t   i_bram_addr,
    input  rate_code_t   i_rate,
    input  logic [11:0]  i_len,
    input  scram_state_t i_seed,
    input  logic [3:0]   i_key,
    input  logic         i_end,
    output int           o_errors,
    output int           o_pairs,
    output int           o_packets
);

    enc_pair_t    exp_q[$];
    logic [6:1]   dly;
    scram_state_t scr;
    int           exp_total = 0;
    int           pkt_pairs = 0;
    int           builds = 0;
    int           starts = 0;
    int           err_cnt = 0;
    int           pair_cnt = 0;
    int           pkt_cnt = 0;
    logic         reset_seen = 1'b0;
    logic         reset_checked = 1'b0;
    logic         end_checked = 1'b0;
    logic         first_cycle = 1'b0;
    logic         done_due = 1'b0;

    assign o_errors  = err_cnt;
    assign o_pairs   = pair_cnt;
    assign o_packets = pkt_cnt;

    function automatic int dbps_of(rate_code_t rate);
        case (rate)
            4'b1011: return 24;
            4'b1111: return 36;
            4'b1010: return 48;
            4'b1110: return 72;
            4'b1001: return 96;
            4'b1101: return 144;
            4'b1000: return 192;
            4'b1100: return 216;
            default: return 24;
        endcase
    endfunction

    function automatic int expected_transfers(rate_code_t rate, int len);
        int n_dbps;
        int n_data;
        n_dbps = dbps_of(rate);
        n_data = 16 + 8 * len + 6;
        return 24 + n_dbps * ((n_data + n_dbps - 1) / n_dbps);
    endfunction

    // Word 0 carries the SIGNAL field, the rest a pattern of the whole address
    function automatic bram_word_t ram_word(rate_code_t rate, int len, logic [3:0] key, int addr);
        logic [23:0] sig;
        logic [31:0] a;
        bram_word_t  w;
        a = 32'(addr);
        w = {a * 32'h9E3779B1 ^ {28'd0, key}, ~a * 32'h85EBCA6B + {key, 28'd0}};
        if (addr == 0) begin
            sig       = '0;
            sig[3:0]  = rate;
            sig[16:5] = 12'(len);
            sig[17]   = ^sig[16:0];
            w[23:0]   = sig;
        end
        return w;
    endfunction

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////
    // Scrambler, CRC and encoder model
    //////////////////////////////////////////////////

    // x^7 + x^4 + 1, output fed back into the first stage
    task automatic scramble(output logic b);
        b   = scr[6] ^ scr[3];
        scr = {scr[5:0], b};
    endtask

    // dly[1] holds the previous bit
    task automatic encode_bit(input logic b);
        enc_pair_t p;
        p[0] = b ^ dly[2] ^ dly[3] ^ dly[5] ^ dly[6];
        p[1] = b ^ dly[1] ^ dly[2] ^ dly[3] ^ dly[6];
        exp_q.push_back(p);
        dly = {dly[5:1], b};
    endtask

    task automatic build_expected();
        bram_word_t w0;
        bram_word_t w;
        crc_t       crc;
        logic       s;
        logic       d;
        int         len;
        int         n_data;
        len = int'(i_len);
        exp_q.delete();
        w0  = ram_word(i_rate, len, i_key, 0);
        dly = '0;
        for (int i = 0; i < 24; i++) begin
            encode_bit(w0[i]);
        end
        // DATA restarts the encoder and seeds the scrambler
        dly = '0;
        scr = i_seed;
        for (int i = 0; i < 16; i++) begin
            scramble(s);
            encode_bit(s);
        end
        crc = '1;
        for (int k = 0; k < 8 * (len - 4); k++) begin
            w   = ram_word(i_rate, len, i_key, 2 + k / 64);
            d   = w[k % 64];
            crc = (crc[0] ^ d) ? (crc >> 1) ^ 32'hEDB88320 : crc >> 1;
            scramble(s);
            encode_bit(s ^ d);
        end
        crc = ~crc;
        for (int i = 0; i < 32; i++) begin
            scramble(s);
            encode_bit(s ^ crc[i]);
        end
        for (int i = 0; i < 6; i++) begin
            encode_bit(1'b0);
        end
        exp_total = expected_transfers(i_rate, len);
        n_data    = 16 + 8 * len + 6;
        for (int i = 24 + n_data; i < exp_total; i++) begin
            scramble(s);
            encode_bit(s);
        end
    endtask

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        enc_pair_t want;
        if (reset_int) begin
            reset_seen = 1'b1;
        end else begin
            if (reset_seen && !reset_checked) begin
                reset_checked = 1'b1;
                if (i_enc_valid !== 1'b0 || i_tx_started !== 1'b0 || i_tx_done !== 1'b0 ||
                    i_bram_addr !== '0) begin
                    flag_error("outputs not at their reset values");
                end
            end
            if (first_cycle && i_enc_valid !== 1'b1) begin
                flag_error("no valid pair one cycle after start");
            end
            first_cycle = 1'b0;
            // tx_done belongs to the cycle right after the last pair
            if ((i_tx_done === 1'b1) != done_due) begin
                flag_error("tx_done not in the cycle after the last pair");
            end
            done_due = 1'b0;
            if (i_tx_started === 1'b1) begin
                starts++;
            end
            if (i_enc_valid && i_enc_ready) begin
                pair_cnt++;
                pkt_pairs++;
                if (exp_q.size() == 0) begin
                    flag_error($sformatf("packet %0d has a pair beyond %0d", builds, exp_total));
                end else begin
                    want = exp_q.pop_front();
                    if (i_enc_bits !== want) begin
                        flag_error($sformatf("packet %0d pair %0d is %b, expected %b",
                                             builds, pkt_pairs, i_enc_bits, want));
                    end
                    done_due = (exp_q.size() == 0);
                end
                if (i_tx_started !== (pkt_pairs == 1)) begin
                    flag_error($sformatf("tx_started is %b at pair %0d", i_tx_started,
                                         pkt_pairs));
                end
            end else if (i_tx_started === 1'b1) begin
                flag_error("tx_started without a transfer");
            end
            if (i_tx_done === 1'b1) begin
                pkt_cnt++;
                if (pkt_pairs != exp_total || exp_q.size() != 0 || i_enc_valid) begin
                    flag_error($sformatf("packet %0d ended after %0d pairs, expected %0d",
                                         builds, pkt_pairs, exp_total));
                end
            end
            if (i_tx_start && !i_enc_valid) begin
                if (builds != pkt_cnt) begin
                    flag_error("new start before the previous packet was done");
                end
                build_expected();
                builds++;
                pkt_pairs   = 0;
                first_cycle = 1'b1;
            end
            if (i_end && !end_checked) begin
                end_checked = 1'b1;
                if (starts != builds || pkt_cnt != builds) begin
                    flag_error($sformatf("%0d packets, %0d started pulses, %0d done pulses",
                                         builds, starts, pkt_cnt));
                end
            end
        end
    end

endmodule

/* verif/tb_dot11_tx_bits.sv */
/* Testbench of the transmit bit front end.
   RAM model reads with one cycle of latency and is refilled before each packet.
   Rows with the throttle flag drop i_enc_ready at random. */
`timescale 1ns/1ps

module tb_dot11_tx_bits
    import dot11_tx_pkg::*;
();

    localparam int N_ROWS = 8;

    // One stimulus row
    typedef struct packed {
        rate_code_t   rate;
        logic [11:0]  len;
        scram_state_t seed;
        logic [3:0]   key;
        logic         throttle;
    } stim_row_t;

    logic         clk;
    logic         reset_int;
    logic         i_tx_start;
    scram_state_t i_init_scram_state;
    bram_word_t   i_bram_din;
    bram_addr_t   o_bram_addr;
    logic         i_enc_ready;
    logic         o_enc_valid;
    enc_pair_t    o_enc_bits;
    logic         o_tx_started;
    logic         o_tx_done;
    stim_row_t    rows [N_ROWS];
    stim_row_t    cur;
    bram_word_t   ram [0:31];
    logic         throttle_en;
    logic         run_end;
    integer       seed;
    int           cycles = 0;
    int           limit = 0;
    int           errors;
    int           pairs;
    int           packets;

    dot11_tx_bits DUT (
        .clk                (clk),
        .reset_int          (reset_int),
        .i_tx_start         (i_tx_start),
        .i_init_scram_state (i_init_scram_state),
        .i_bram_din         (i_bram_din),
        .o_bram_addr        (o_bram_addr),
        .i_enc_ready        (i_enc_ready),
        .o_enc_valid        (o_enc_valid),
        .o_enc_bits         (o_enc_bits),
        .o_tx_started       (o_tx_started),
        .o_tx_done          (o_tx_done)
    );

    dot11_tx_checker u_checker (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_tx_start   (i_tx_start),
        .i_enc_ready  (i_enc_ready),
        .i_enc_valid  (o_enc_valid),
        .i_enc_bits   (o_enc_bits),
        .i_tx_started (o_tx_started),
        .i_tx_done    (o_tx_done),
        .i_bram_addr  (o_bram_addr),
        .i_rate       (cur.rate),
        .i_len        (cur.len),
        .i_seed       (cur.seed),
        .i_key        (cur.key),
        .i_end        (run_end),
        .o_errors     (errors),
        .o_pairs      (pairs),
        .o_packets    (packets)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // RAM read port and ready throttle
    always @(posedge clk) begin
        i_bram_din <= ram[o_bram_addr[4:0]];
        if (throttle_en) begin
            i_enc_ready <= (($random(seed) & 3) != 0);
        end else begin
            i_enc_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the packet stream did not finish within %0d cycles", limit);
            $display("Packets %0d, pairs %0d, errors %0d", packets, pairs, errors);
            $display("sim failed");
            $finish;
        end
    end

    // Rate code, length in bytes, seed, fill key, throttle
    task automatic load_table();
        rows[0] = '{4'b1011, 12'd10,  7'h5D, 4'd1, 1'b0};
        rows[1] = '{4'b1100, 12'd40,  7'h7F, 4'd2, 1'b0};
        rows[2] = '{4'b1001, 12'd100, 7'h2A, 4'd3, 1'b0};
        // Same packet as row 2, throttled
        rows[3] = '{4'b1001, 12'd100, 7'h2A, 4'd3, 1'b1};
        rows[4] = '{4'b1111, 12'd4,   7'h11, 4'd4, 1'b0};
        rows[5] = '{4'b1110, 12'd33,  7'h63, 4'd5, 1'b1};
        // Reserved rate code, padded as 6 Mbps
        rows[6] = '{4'b0101, 12'd20,  7'h01, 4'd6, 1'b0};
        rows[7] = '{4'b1000, 12'd61,  7'h46, 4'd7, 1'b1};
    endtask

    task automatic send_packet(input stim_row_t row);
        for (int a = 0; a < 32; a++) begin
            ram[a] = u_checker.ram_word(row.rate, int'(row.len), row.key, a);
        end
        cur                <= row;
        throttle_en        <= row.throttle;
        i_init_scram_state <= row.seed;
        @(posedge clk);
        i_tx_start <= 1'b1;
        @(posedge clk);
        i_tx_start <= 1'b0;
        do begin
            @(posedge clk);
        end while (o_tx_done !== 1'b1);
        @(posedge clk);
    endtask

    initial begin
        int total;
        reset_int          = 1'b1;
        i_tx_start         = 1'b0;
        i_init_scram_state = '0;
        i_bram_din         = '0;
        i_enc_ready        = 1'b0;
        throttle_en        = 1'b0;
        run_end            = 1'b0;
        seed               = 32'h2bd;
        cur                = '0;
        load_table();
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += u_checker.expected_transfers(rows[r].rate, int'(rows[r].len));
        end
        limit = 4 * total + 200;
        repeat (16) @(posedge clk);
        reset_int <= 1'b0;
        repeat (4) @(posedge clk);
        for (int r = 0; r < N_ROWS; r++) begin
            send_packet(rows[r]);
        end
        run_end <= 1'b1;
        repeat (2) @(posedge clk);
        $display("Packets %0d, pairs %0d, errors %0d", packets, pairs, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hw/dot11_tx_pkg.sv
hw/dot11_crc32.sv
hw/dot11_conv_encoder.sv
hw/dot11_bit_source.sv
hw/dot11_tx_bits.sv
verif/dot11_tx_checker.sv
verif/tb_dot11_tx_bits.sv

/* Bender.yml */
package:
  name: dot11_tx_bits

export_include_dirs:
  - include

sources:
  - hw/dot11_tx_pkg.sv
  - hw/dot11_crc32.sv
  - hw/dot11_conv_encoder.sv
  - hw/dot11_bit_source.sv
  - hw/dot11_tx_bits.sv
  - target: test
    files:
      - verif/dot11_tx_checker.sv
      - verif/tb_dot11_tx_bits.sv
